//--- source/sw_pkg.sv
`default_nettype none

package sw_pkg;

    // score word
    localparam int score_w = 14;
    typedef logic signed [score_w-1:0] score_t;

    // base encoding
    typedef logic [1:0] base_t;
    localparam base_t base_a = 2'd0;
    localparam base_t base_c = 2'd1;
    localparam base_t base_g = 2'd2;
    localparam base_t base_t_code = 2'd3;

    // column and antidiagonal counters
    localparam int col_w = 10;

    // cells that are not valid
    localparam score_t neg_inf = -14'sd4096;

    // scoring
    localparam score_t match_score = 14'sd2;
    localparam score_t mismatch_score = -14'sd3;
    // first position of a gap
    localparam score_t gap_open = -14'sd12;
    // each further position
    localparam score_t gap_extend = -14'sd1;

endpackage

`default_nettype wire

//--- source/sw_pe.sv
`timescale 1ns/1ps
`default_nettype none

module sw_pe (
    input  wire                 i_clk,
    input  wire                 i_rst,
    input  wire                 i_load,
    input  wire sw_pkg::base_t  i_query_base,
    input  wire                 i_valid,
    input  wire sw_pkg::base_t  i_ref_base,
    input  wire sw_pkg::score_t i_h_diag,
    input  wire sw_pkg::score_t i_h_top,
    input  wire sw_pkg::score_t i_f_top,
    input  wire sw_pkg::score_t i_h_left_init,
    input  wire                 i_clear,
    output logic                o_valid,
    output sw_pkg::base_t       o_ref_base,
    output sw_pkg::score_t      o_h,
    output sw_pkg::score_t      o_h_prev,
    output sw_pkg::score_t      o_f
);

    sw_pkg::base_t  q_base;
    sw_pkg::base_t  q_use;
    sw_pkg::score_t e_reg;
    sw_pkg::score_t e_new;
    sw_pkg::score_t f_new;
    sw_pkg::score_t h_new;
    sw_pkg::score_t diag_sum;
    sw_pkg::score_t h_open;
    sw_pkg::score_t top_open;
    sw_pkg::score_t e_ext;
    sw_pkg::score_t f_ext;

    // affine recurrences, o_h is the left H of this row
    always_comb begin
        // column 0 meets the query in the cycle it is latched
        q_use = i_load ? i_query_base : q_base;
        h_open = o_h + sw_pkg::gap_open;
        e_ext = e_reg + sw_pkg::gap_extend;
        e_new = (h_open > e_ext) ? h_open : e_ext;
        top_open = i_h_top + sw_pkg::gap_open;
        f_ext = i_f_top + sw_pkg::gap_extend;
        f_new = (top_open > f_ext) ? top_open : f_ext;
        if (q_use == i_ref_base) begin
            diag_sum = i_h_diag + sw_pkg::match_score;
        end else begin
            diag_sum = i_h_diag + sw_pkg::mismatch_score;
        end
        h_new = diag_sum;
        if (e_new > h_new) begin
            h_new = e_new;
        end
        if (f_new > h_new) begin
            h_new = f_new;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else if (i_clear) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_load) begin
            q_base <= i_query_base;
        end
        o_ref_base <= i_ref_base;
        if (i_valid) begin
            o_h <= h_new;
            o_h_prev <= o_h;
            e_reg <= e_new;
            o_f <= f_new;
        end else begin
            // idle row waits at its left boundary
            o_h <= i_h_left_init;
            e_reg <= sw_pkg::neg_inf;
        end
    end

endmodule

`default_nettype wire

//--- source/sw_pe_array.sv
`timescale 1ns/1ps
`default_nettype none

module sw_pe_array #(
    parameter int n_pe = 64
) (
    input  wire                             i_clk,
    input  wire                             i_rst,
    input  wire                             i_load,
    input  wire sw_pkg::base_t [n_pe-1:0]   i_query,
    input  wire                             i_feed,
    input  wire sw_pkg::base_t              i_ref_base,
    input  wire sw_pkg::score_t             i_top_h,
    input  wire                             i_clear,
    output sw_pkg::score_t [n_pe-1:0]       o_h_bus,
    output logic                            o_last_valid
);

    logic           valid [n_pe];
    sw_pkg::base_t  ref_b [n_pe];
    sw_pkg::score_t h [n_pe];
    sw_pkg::score_t h_prev [n_pe];
    sw_pkg::score_t f [n_pe];
    sw_pkg::score_t top_diag;

    // row 0 diagonal is last column's top boundary, the corner when idle
    always_ff @(posedge i_clk) begin
        if (i_feed) begin
            top_diag <= i_top_h;
        end else begin
            top_diag <= '0;
        end
    end

    genvar r;
    generate
        for (r = 0; r < n_pe; r++) begin : g_row
            localparam sw_pkg::score_t left_init =
                sw_pkg::score_t'(int'(sw_pkg::gap_open) + int'(sw_pkg::gap_extend) * r);

            if (r == 0) begin : g_first
                sw_pe u_pe (
                    .i_clk        (i_clk),
                    .i_rst        (i_rst),
                    .i_load       (i_load),
                    .i_query_base (i_query[r]),
                    .i_valid      (i_feed),
                    .i_ref_base   (i_ref_base),
                    .i_h_diag     (top_diag),
                    .i_h_top      (i_top_h),
                    .i_f_top      (sw_pkg::neg_inf),
                    .i_h_left_init(left_init),
                    .i_clear      (i_clear),
                    .o_valid      (valid[r]),
                    .o_ref_base   (ref_b[r]),
                    .o_h          (h[r]),
                    .o_h_prev     (h_prev[r]),
                    .o_f          (f[r])
                );
            end else begin : g_next
                sw_pe u_pe (
                    .i_clk        (i_clk),
                    .i_rst        (i_rst),
                    .i_load       (i_load),
                    .i_query_base (i_query[r]),
                    .i_valid      (valid[r-1]),
                    .i_ref_base   (ref_b[r-1]),
                    .i_h_diag     (h_prev[r-1]),
                    .i_h_top      (h[r-1]),
                    .i_f_top      (f[r-1]),
                    .i_h_left_init(left_init),
                    .i_clear      (i_clear),
                    .o_valid      (valid[r]),
                    .o_ref_base   (ref_b[r]),
                    .o_h          (h[r]),
                    .o_h_prev     (h_prev[r]),
                    .o_f          (f[r])
                );
            end

            // invalid rows never win the max
            assign o_h_bus[r] = valid[r] ? h[r] : sw_pkg::neg_inf;
        end
    endgenerate

    assign o_last_valid = valid[n_pe-1];

endmodule

`default_nettype wire

//--- source/sw_max_tree.sv
`timescale 1ns/1ps
`default_nettype none

module sw_max_tree #(
    parameter int n_pe = 64
) (
    input  wire sw_pkg::score_t [n_pe-1:0] i_h_bus,
    output sw_pkg::score_t                 o_max,
    output logic [$clog2(n_pe)-1:0]        o_row
);

    localparam int row_w = $clog2(n_pe);
    localparam int levels = $clog2(n_pe);

    sw_pkg::score_t   val [levels+1][n_pe];
    logic [row_w-1:0] idx [levels+1][n_pe];

    always_comb begin
        for (int l = 0; l <= levels; l++) begin
            for (int i = 0; i < n_pe; i++) begin
                val[l][i] = sw_pkg::neg_inf;
                idx[l][i] = '0;
            end
        end
        for (int i = 0; i < n_pe; i++) begin
            val[0][i] = i_h_bus[i];
            idx[0][i] = row_w'(i);
        end
        // pairwise reduction, ties go to the odd (higher) row
        for (int l = 0; l < levels; l++) begin
            for (int i = 0; i < (n_pe >> (l + 1)); i++) begin
                if (val[l][2*i] > val[l][2*i+1]) begin
                    val[l+1][i] = val[l][2*i];
                    idx[l+1][i] = idx[l][2*i];
                end else begin
                    val[l+1][i] = val[l][2*i+1];
                    idx[l+1][i] = idx[l][2*i+1];
                end
            end
        end
    end

    assign o_max = val[levels][0];
    assign o_row = idx[levels][0];

endmodule

`default_nettype wire

//--- source/sw_xdrop_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module sw_xdrop_ctrl #(
    parameter int n_pe = 64,
    parameter int xdrop_limit = 250
) (
    input  wire                             i_clk,
    input  wire                             i_rst,
    input  wire                             i_start,
    input  wire sw_pkg::score_t             i_diag_max,
    input  wire [$clog2(n_pe)-1:0]          i_diag_row,
    input  wire                             i_last_valid,
    output logic                            o_load,
    output logic                            o_feed,
    output logic                            o_clear,
    output sw_pkg::score_t                  o_top_h,
    output logic                            o_done,
    output logic                            o_dropped,
    output sw_pkg::score_t                  o_max_score,
    output logic [$clog2(n_pe)-1:0]         o_max_row,
    output logic [sw_pkg::col_w-1:0]        o_max_col,
    output logic [sw_pkg::col_w-1:0]        o_end_diag
);

    localparam int row_w = $clog2(n_pe);
    localparam int col_w = sw_pkg::col_w;

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_stream = 2'd1;
    localparam logic [1:0] st_flush = 2'd2;
    localparam logic [1:0] st_wait_low = 2'd3;

    logic [1:0]       state;
    logic [col_w-1:0] col_cnt;
    logic [col_w-1:0] diag_cnt;
    logic             have_best;
    sw_pkg::score_t   best_score;
    logic [row_w-1:0] best_row;
    logic [col_w-1:0] best_col;

    logic             record;
    logic             drop;
    logic             last_diag;
    logic             better;
    logic [col_w-1:0] top_col;
    sw_pkg::score_t   best_score_nxt;
    logic [row_w-1:0] best_row_nxt;
    logic [col_w-1:0] best_col_nxt;

    assign o_load = (state == st_idle) && i_start;
    assign o_feed = i_start && ((state == st_idle) || (state == st_stream));

    // top boundary of the fed column is the gap of length col+1
    assign top_col = (state == st_idle) ? '0 : col_cnt;
    assign o_top_h = sw_pkg::score_t'(int'(sw_pkg::gap_open)
                     + int'(sw_pkg::gap_extend) * int'(top_col));

    // one antidiagonal on the bus per cycle after column 0
    assign record = (state == st_stream) || (state == st_flush);
    assign drop = record && have_best
                  && (int'(i_diag_max) < int'(best_score) - xdrop_limit);
    assign last_diag = (state == st_flush) && i_last_valid
                       && (diag_cnt == col_cnt + col_w'(n_pe - 2));
    // later antidiagonal wins ties
    assign better = !have_best || (i_diag_max >= best_score);

    always_comb begin
        best_score_nxt = best_score;
        best_row_nxt = best_row;
        best_col_nxt = best_col;
        if (better) begin
            best_score_nxt = i_diag_max;
            best_row_nxt = i_diag_row;
            best_col_nxt = diag_cnt - col_w'(i_diag_row);
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state <= st_idle;
            col_cnt <= '0;
            diag_cnt <= '0;
            have_best <= 1'b0;
            best_score <= '0;
            best_row <= '0;
            best_col <= '0;
            o_clear <= 1'b0;
            o_done <= 1'b0;
            o_dropped <= 1'b0;
            o_max_score <= '0;
            o_max_row <= '0;
            o_max_col <= '0;
            o_end_diag <= '0;
        end else begin
            o_done <= 1'b0;
            o_clear <= 1'b0;
            case (state)
                st_idle: begin
                    if (i_start) begin
                        state <= st_stream;
                        col_cnt <= col_w'(1);
                        diag_cnt <= '0;
                        have_best <= 1'b0;
                    end
                end
                st_stream, st_flush: begin
                    if (state == st_stream) begin
                        if (i_start) begin
                            col_cnt <= col_cnt + 1'b1;
                        end else begin
                            state <= st_flush;
                        end
                    end
                    if (drop) begin
                        // best score stays as it was before this antidiagonal
                        state <= st_wait_low;
                        o_clear <= 1'b1;
                        o_done <= 1'b1;
                        o_dropped <= 1'b1;
                        o_end_diag <= diag_cnt;
                        o_max_score <= best_score;
                        o_max_row <= best_row;
                        o_max_col <= best_col;
                    end else begin
                        have_best <= 1'b1;
                        best_score <= best_score_nxt;
                        best_row <= best_row_nxt;
                        best_col <= best_col_nxt;
                        diag_cnt <= diag_cnt + 1'b1;
                        if (last_diag) begin
                            state <= st_idle;
                            o_done <= 1'b1;
                            o_dropped <= 1'b0;
                            o_end_diag <= diag_cnt;
                            o_max_score <= best_score_nxt;
                            o_max_row <= best_row_nxt;
                            o_max_col <= best_col_nxt;
                        end
                    end
                end
                default: begin
                    // rest of the stream is ignored
                    if (!i_start) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/sw_align_top.sv
`timescale 1ns/1ps
`default_nettype none

module sw_align_top #(
    parameter int n_pe = 64,
    parameter int xdrop_limit = 250
) (
    input  wire                             i_clk,
    input  wire                             i_rst,
    input  wire                             i_start,
    input  wire sw_pkg::base_t [n_pe-1:0]   i_query,
    input  wire sw_pkg::base_t              i_ref_base,
    output logic                            o_done,
    output sw_pkg::score_t                  o_max_score,
    output logic [$clog2(n_pe)-1:0]         o_max_row,
    output logic [sw_pkg::col_w-1:0]        o_max_col,
    output logic                            o_dropped,
    output logic [sw_pkg::col_w-1:0]        o_end_diag
);

    localparam int row_w = $clog2(n_pe);

    logic                        load;
    logic                        feed;
    logic                        clear;
    sw_pkg::score_t              top_h;
    sw_pkg::score_t [n_pe-1:0]   h_bus;
    logic                        last_valid;
    sw_pkg::score_t              diag_max;
    logic [row_w-1:0]            diag_row;

    sw_pe_array #(.n_pe(n_pe)) u_array (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_load      (load),
        .i_query     (i_query),
        .i_feed      (feed),
        .i_ref_base  (i_ref_base),
        .i_top_h     (top_h),
        .i_clear     (clear),
        .o_h_bus     (h_bus),
        .o_last_valid(last_valid)
    );

    sw_max_tree #(.n_pe(n_pe)) u_tree (
        .i_h_bus(h_bus),
        .o_max  (diag_max),
        .o_row  (diag_row)
    );

    sw_xdrop_ctrl #(.n_pe(n_pe), .xdrop_limit(xdrop_limit)) u_ctrl (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_start     (i_start),
        .i_diag_max  (diag_max),
        .i_diag_row  (diag_row),
        .i_last_valid(last_valid),
        .o_load      (load),
        .o_feed      (feed),
        .o_clear     (clear),
        .o_top_h     (top_h),
        .o_done      (o_done),
        .o_dropped   (o_dropped),
        .o_max_score (o_max_score),
        .o_max_row   (o_max_row),
        .o_max_col   (o_max_col),
        .o_end_diag  (o_end_diag)
    );

endmodule

`default_nettype wire

//--- test/sw_align_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module sw_align_assertions #(
    parameter int n_pe = 64
) (
    input wire                       i_clk,
    input wire                       i_rst,
    input wire                       i_start,
    input wire                       i_done,
    input wire                       i_dropped,
    input wire [$clog2(n_pe)-1:0]    i_max_row,
    input wire [sw_pkg::col_w-1:0]   i_max_col,
    input wire [sw_pkg::col_w-1:0]   i_end_diag
);

    int failures = 0;

    done_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        i_done |=> !i_done)
    else begin
        failures++;
        $error("o_done stayed high for more than one cycle");
    end

    quiet_in_reset: assert property (@(posedge i_clk)
        i_rst |-> !i_done && !i_dropped)
    else begin
        failures++;
        $error("o_done or o_dropped high during reset");
    end

    // last high i_start cycle is n_pe+1 cycles before the done cycle
    done_latency: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_done && !i_dropped) |-> $past(i_start, n_pe + 1) && !$past(i_start, n_pe))
    else begin
        failures++;
        $error("o_done not n_pe+1 cycles after the end of the stream");
    end

    // best cell lies on or before the last antidiagonal
    row_range: assert property (@(posedge i_clk) disable iff (i_rst)
        i_done |-> int'(i_max_row) + int'(i_max_col) <= int'(i_end_diag))
    else begin
        failures++;
        $error("o_max_row out of range");
    end

endmodule

bind sw_align_top sw_align_assertions #(
    .n_pe(n_pe)
) u_assertions (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_start   (i_start),
    .i_done    (o_done),
    .i_dropped (o_dropped),
    .i_max_row (o_max_row),
    .i_max_col (o_max_col),
    .i_end_diag(o_end_diag)
);

`default_nettype wire

//--- test/tb_sw_align.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sw_align;

    localparam int n_pe = 8;
    localparam int xdrop_limit = 40;
    localparam int max_len = 160;
    localparam int row_w = $clog2(n_pe);
    // eight runs of 8, 3 x 20, 3, 158, 158 and 16 bases
    localparam int total_len = 8 + 3 * 20 + 3 + 158 + 158 + 16;
    localparam int timeout_cycles = total_len + 8 * (n_pe + 20);
    localparam int neg = int'(sw_pkg::neg_inf);

    logic                     i_clk;
    logic                     i_rst;
    logic                     i_start;
    sw_pkg::base_t [n_pe-1:0] i_query;
    sw_pkg::base_t            i_ref_base;
    logic                     o_done;
    sw_pkg::score_t           o_max_score;
    logic [row_w-1:0]         o_max_row;
    logic [sw_pkg::col_w-1:0] o_max_col;
    logic                     o_dropped;
    logic [sw_pkg::col_w-1:0] o_end_diag;

    int seed;
    int cycle_cnt = 0;
    int done_cnt = 0;
    int run_cnt = 0;
    int test_errs = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;

    sw_pkg::base_t [n_pe-1:0] query;
    sw_pkg::base_t            ref_seq [max_len];
    int                       ref_len;

    int exp_score;
    int exp_row;
    int exp_col;
    int exp_dropped;
    int exp_end;
    int got_score;
    int got_row;
    int got_col;
    int got_dropped;
    int got_end;

    sw_align_top #(
        .n_pe       (n_pe),
        .xdrop_limit(xdrop_limit)
    ) i_dut (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_start    (i_start),
        .i_query    (i_query),
        .i_ref_base (i_ref_base),
        .o_done     (o_done),
        .o_max_score(o_max_score),
        .o_max_row  (o_max_row),
        .o_max_col  (o_max_col),
        .o_dropped  (o_dropped),
        .o_end_diag (o_end_diag)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_cnt++;
        if (cycle_cnt > timeout_cycles) begin
            $display("timeout: no result within %0d cycles", timeout_cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // results are stable mid-cycle
    always @(negedge i_clk) begin
        if (o_done) begin
            done_cnt++;
            got_score = o_max_score;
            got_row = o_max_row;
            got_col = o_max_col;
            got_dropped = o_dropped;
            got_end = o_end_diag;
        end
    end

    // gap of len positions, length zero is the corner
    function automatic int gap_score(input int len);
        if (len == 0) begin
            return 0;
        end
        return int'(sw_pkg::gap_open) + int'(sw_pkg::gap_extend) * (len - 1);
    endfunction

    function automatic int max2(input int a, input int b);
        return (a > b) ? a : b;
    endfunction

    // full matrix, then antidiagonals in order with x-drop
    task automatic align_model();
        int h_m [n_pe][max_len];
        int e_m [n_pe][max_len];
        int f_m [n_pe][max_len];
        int hl;
        int el;
        int ht;
        int ft;
        int hd;
        int sub;
        int d_max;
        int d_row;
        int best;
        int best_row;
        int best_col;
        bit have_best;
        for (int c = 0; c < ref_len; c++) begin
            for (int r = 0; r < n_pe; r++) begin
                hl = (c == 0) ? gap_score(r + 1) : h_m[r][c-1];
                el = (c == 0) ? neg : e_m[r][c-1];
                ht = (r == 0) ? gap_score(c + 1) : h_m[r-1][c];
                ft = (r == 0) ? neg : f_m[r-1][c];
                if (r == 0) begin
                    hd = gap_score(c);
                end else if (c == 0) begin
                    hd = gap_score(r);
                end else begin
                    hd = h_m[r-1][c-1];
                end
                sub = (query[r] == ref_seq[c]) ? int'(sw_pkg::match_score)
                                               : int'(sw_pkg::mismatch_score);
                e_m[r][c] = max2(hl + int'(sw_pkg::gap_open), el + int'(sw_pkg::gap_extend));
                f_m[r][c] = max2(ht + int'(sw_pkg::gap_open), ft + int'(sw_pkg::gap_extend));
                h_m[r][c] = max2(hd + sub, max2(e_m[r][c], f_m[r][c]));
            end
        end
        have_best = 1'b0;
        best = 0;
        best_row = 0;
        best_col = 0;
        exp_dropped = 0;
        exp_end = ref_len + n_pe - 2;
        for (int d = 0; d <= ref_len + n_pe - 2; d++) begin
            d_max = neg;
            d_row = 0;
            for (int r = 0; r < n_pe; r++) begin
                if (d - r >= 0 && d - r < ref_len && h_m[r][d-r] >= d_max) begin
                    d_max = h_m[r][d-r];
                    d_row = r;
                end
            end
            if (have_best && d_max < best - xdrop_limit) begin
                exp_dropped = 1;
                exp_end = d;
                break;
            end
            if (!have_best || d_max >= best) begin
                best = d_max;
                best_row = d_row;
                best_col = d - d_row;
            end
            have_best = 1'b1;
        end
        exp_score = best;
        exp_row = best_row;
        exp_col = best_col;
    endtask

    task automatic check_value(input string name, input string what,
                               input int expected, input int actual);
        assert (expected == actual) else begin
            $display("ERROR %s %s: expected %0d, actual %0d", name, what, expected, actual);
            test_errs++;
        end
    endtask

    task automatic random_query(input bit ac_only);
        int rnd;
        for (int r = 0; r < n_pe; r++) begin
            rnd = $random(seed);
            query[r] = ac_only ? {1'b0, rnd[0]} : rnd[1:0];
        end
    endtask

    task automatic random_ref(input int start, input int len, input bit gt_only);
        int rnd;
        for (int i = start; i < start + len; i++) begin
            rnd = $random(seed);
            ref_seq[i] = gt_only ? {1'b1, rnd[0]} : rnd[1:0];
        end
        ref_len = start + len;
    endtask

    task automatic copy_query();
        for (int r = 0; r < n_pe; r++) begin
            ref_seq[r] = query[r];
        end
        ref_len = n_pe;
    endtask

    task automatic run_alignment(input string name);
        align_model();
        // no done pulse may show up between runs
        check_value(name, "done count before run", run_cnt, done_cnt);
        for (int i = 0; i < ref_len; i++) begin
            @(posedge i_clk);
            i_start <= 1'b1;
            i_ref_base <= ref_seq[i];
            if (i == 0) begin
                i_query <= query;
            end
        end
        @(posedge i_clk);
        i_start <= 1'b0;
        while (done_cnt == run_cnt) begin
            @(posedge i_clk);
        end
        run_cnt++;
        check_value(name, "score", exp_score, got_score);
        check_value(name, "row", exp_row, got_row);
        check_value(name, "col", exp_col, got_col);
        check_value(name, "dropped", exp_dropped, got_dropped);
        check_value(name, "end diag", exp_end, got_end);
        repeat (2) @(posedge i_clk);
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    // query of A/C only, then a G/T tail that can never match
    task automatic drop_run(input string name);
        random_query(1'b1);
        copy_query();
        random_ref(n_pe, 150, 1'b1);
        run_alignment(name);
        check_value(name, "dropped flag", 1, got_dropped);
        check_value(name, "held score", n_pe * int'(sw_pkg::match_score), got_score);
        check_value(name, "held row", n_pe - 1, got_row);
        check_value(name, "held col", n_pe - 1, got_col);
        finish_test(name);
    endtask

    initial begin
        seed = 32'he58b;
        i_rst = 1'b1;
        i_start = 1'b0;
        i_query = '0;
        i_ref_base = '0;
        repeat (2) @(posedge i_clk);
        i_rst <= 1'b0;
        @(posedge i_clk);

        random_query(1'b0);
        copy_query();
        run_alignment("match_full");
        check_value("match_full", "score", n_pe * int'(sw_pkg::match_score), got_score);
        check_value("match_full", "row", n_pe - 1, got_row);
        check_value("match_full", "col", n_pe - 1, got_col);
        check_value("match_full", "dropped", 0, got_dropped);
        finish_test("match_full");

        for (int t = 0; t < 3; t++) begin
            random_query(1'b0);
            random_ref(0, 20, 1'b0);
            run_alignment($sformatf("random_20_%0d", t));
            finish_test($sformatf("random_20_%0d", t));
        end

        // rows 3 and up only reachable through gaps
        random_query(1'b0);
        random_ref(0, 3, 1'b0);
        run_alignment("short_ref");
        finish_test("short_ref");

        drop_run("xdrop_stop");

        drop_run("back_to_back_drop");
        random_query(1'b0);
        random_ref(0, 16, 1'b0);
        run_alignment("back_to_back_next");
        finish_test("back_to_back_next");

        $display("tests passed %0d, failed %0d, assertion failures %0d",
                 pass_cnt, fail_cnt, i_dut.u_assertions.failures);
        if (fail_cnt == 0 && i_dut.u_assertions.failures == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
source/sw_pkg.sv
source/sw_pe.sv
source/sw_pe_array.sv
source/sw_max_tree.sv
source/sw_xdrop_ctrl.sv
source/sw_align_top.sv
test/sw_align_assertions.sv
test/tb_sw_align.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_sw_align \
    -f vlog.f -o sim_tb

out=$(./obj_dir/sim_tb +verilator+error+limit+100 2>&1) || true
echo "$out"
echo "$out" | grep -q "^Simulation finished: PASS$"
